//--- decode_exec.f
src/rv_exec_pkg.sv
src/stage_bus_if.sv
src/inst_decoder.sv
src/id_ex_reg.sv
src/alu_exec.sv
src/decode_exec_top.sv
tests/tb_decode_exec.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_decode_exec \
    -f decode_exec.f \
    -o sim_decode_exec
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_decode_exec 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

//--- src/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec
    import rv_exec_pkg::*;
(
    input  logic        I_sys_clk,
    input  logic        I_rst,
    stage_bus_if.dst    bus,
    output logic        out_valid,
    input  logic        out_allowout,
    output xlen_t       out_result,
    output reg_addr_t   out_rd_addr,
    output logic        out_reg_wen,
    output xlen_t       out_pc
);

    xlen_t      op1;
    xlen_t      op2;
    xlen_t      src_a;   // op1, pre-extended for word shifts
    xlen_t      alu_res;
    xlen_t      result;
    logic [5:0] shamt;

    always_comb begin
        case (bus.op1_sel)
            OP1_RS1: op1 = bus.rs1;
            OP1_PC:  op1 = bus.pc;
            default: op1 = '0;
        endcase
    end

    assign op2   = (bus.op2_sel == OP2_IMM) ? bus.imm : bus.rs2;
    assign shamt = bus.word_op ? {1'b0, op2[4:0]} : op2[5:0];

    // Word right shifts must see a clean 32-bit value in the low half
    always_comb begin
        if (!bus.word_op) begin
            src_a = op1;
        end else if (bus.alu_op == ALU_SRA) begin
            src_a = {{32{op1[31]}}, op1[31:0]};
        end else begin
            src_a = {32'b0, op1[31:0]};
        end
    end

    always_comb begin
        case (bus.alu_op)
            ALU_SUB:  alu_res = src_a - op2;
            ALU_SLL:  alu_res = src_a << shamt;
            ALU_SLT:  alu_res = {63'b0, $signed(src_a) < $signed(op2)};
            ALU_SLTU: alu_res = {63'b0, src_a < op2};
            ALU_XOR:  alu_res = src_a ^ op2;
            ALU_SRL:  alu_res = src_a >> shamt;
            ALU_SRA:  alu_res = $signed(src_a) >>> shamt;
            ALU_OR:   alu_res = src_a | op2;
            ALU_AND:  alu_res = src_a & op2;
            default:  alu_res = src_a + op2;
        endcase
    end

    assign result      = bus.word_op ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;
    assign bus.allowin = !out_valid || out_allowout;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            out_valid <= 1'b0;
        end else if (bus.allowin) begin
            out_valid <= bus.valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (bus.valid && bus.allowin) begin
            out_result  <= result;
            out_rd_addr <= bus.rd_addr;
            out_reg_wen <= bus.reg_wen;
            out_pc      <= bus.pc;
        end
    end

    assert property (@(posedge I_sys_clk) disable iff (I_rst)
        out_valid && !out_allowout |=>
            out_valid && $stable(out_result) && $stable(out_rd_addr) &&
            $stable(out_reg_wen) && $stable(out_pc));

endmodule

`default_nettype wire

//--- src/decode_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_exec_top
    import rv_exec_pkg::*;
(
    input  logic        I_sys_clk,
    input  logic        I_rst,
    input  logic        in_valid,
    output logic        in_allowin,
    input  inst_t       inst,
    input  xlen_t       pc,
    input  xlen_t       rs1_val,
    input  xlen_t       rs2_val,
    output logic        out_valid,
    input  logic        out_allowout,
    output xlen_t       out_result,
    output reg_addr_t   out_rd_addr,
    output logic        out_reg_wen,
    output xlen_t       out_pc
);

    stage_bus_if dec_bus ();   // ID to ID/EX
    stage_bus_if ex_bus ();    // ID/EX to EX

    inst_decoder u_decoder (
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .inst       (inst),
        .pc         (pc),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .bus        (dec_bus.src)
    );

    id_ex_reg u_id_ex (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .in_bus    (dec_bus.dst),
        .out_bus   (ex_bus.src)
    );

    alu_exec u_exec (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .bus          (ex_bus.dst),
        .out_valid    (out_valid),
        .out_allowout (out_allowout),
        .out_result   (out_result),
        .out_rd_addr  (out_rd_addr),
        .out_reg_wen  (out_reg_wen),
        .out_pc       (out_pc)
    );

endmodule

`default_nettype wire

//--- src/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import rv_exec_pkg::*;
(
    input  logic        I_sys_clk,
    input  logic        I_rst,
    stage_bus_if.dst    in_bus,
    stage_bus_if.src    out_bus
);

    logic input_valid;   // Entry holds an instruction

    assign in_bus.allowin = !input_valid || out_bus.allowin;
    assign out_bus.valid  = input_valid;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            input_valid <= 1'b0;
        end else if (in_bus.allowin) begin
            input_valid <= in_bus.valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (in_bus.valid && in_bus.allowin) begin
            out_bus.pc      <= in_bus.pc;
            out_bus.rs1     <= in_bus.rs1;
            out_bus.rs2     <= in_bus.rs2;
            out_bus.imm     <= in_bus.imm;
            out_bus.rd_addr <= in_bus.rd_addr;
            out_bus.reg_wen <= in_bus.reg_wen;
            out_bus.word_op <= in_bus.word_op;
            out_bus.alu_op  <= in_bus.alu_op;
            out_bus.op1_sel <= in_bus.op1_sel;
            out_bus.op2_sel <= in_bus.op2_sel;
        end
    end

    // Stalled by EX, so the held instruction must not change
    assert property (@(posedge I_sys_clk) disable iff (I_rst)
        out_bus.valid && !out_bus.allowin |=>
            out_bus.valid && $stable(out_bus.pc) && $stable(out_bus.rs1) &&
            $stable(out_bus.rs2) && $stable(out_bus.imm) && $stable(out_bus.rd_addr) &&
            $stable(out_bus.reg_wen) && $stable(out_bus.alu_op) && $stable(out_bus.word_op) &&
            $stable(out_bus.op1_sel) && $stable(out_bus.op2_sel));

    assert property (@(posedge I_sys_clk) I_rst |=> !out_bus.valid);

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_exec_pkg::*;
(
    input  logic        in_valid,
    output logic        in_allowin,
    input  inst_t       inst,
    input  xlen_t       pc,
    input  xlen_t       rs1_val,
    input  xlen_t       rs2_val,
    stage_bus_if.src    bus
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_ok;
    logic       w_f3_ok;
    logic       sh6_ok;
    xlen_t      imm_i;
    xlen_t      imm_u;

    function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  f3_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{52{inst[31]}}, inst[31:20]};
    assign imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};

    // Only SUB and SRA may set the alternate funct7
    assign f7_ok   = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign w_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
    assign sh6_ok  = (inst[31:26] == 6'b000000) ||
                     (inst[31:26] == 6'b010000 && funct3 == 3'b101);

    always_comb begin
        bus.alu_op  = ALU_ADD;    // Bubble unless a case below matches
        bus.op1_sel = OP1_ZERO;
        bus.op2_sel = OP2_IMM;
        bus.imm     = '0;
        bus.reg_wen = 1'b0;
        bus.word_op = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_32: begin
                if (f7_ok && (opcode == OPC_OP || w_f3_ok)) begin
                    bus.alu_op  = f3_op(funct3, inst[30]);
                    bus.op1_sel = OP1_RS1;
                    bus.op2_sel = OP2_RS2;
                    bus.word_op = (opcode == OPC_OP_32);
                    bus.reg_wen = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (funct3[1:0] != 2'b01) begin
                    bus.alu_op  = f3_op(funct3, 1'b0);
                    bus.op1_sel = OP1_RS1;
                    bus.imm     = imm_i;
                    bus.reg_wen = 1'b1;
                end else if (sh6_ok) begin
                    bus.alu_op  = f3_op(funct3, inst[30]);
                    bus.op1_sel = OP1_RS1;
                    bus.imm     = {58'b0, inst[25:20]};   // shamt only
                    bus.reg_wen = 1'b1;
                end
            end
            OPC_OP_IMM_32: begin
                if (funct3 == 3'b000) begin
                    bus.op1_sel = OP1_RS1;   // ADDIW
                    bus.imm     = imm_i;
                    bus.word_op = 1'b1;
                    bus.reg_wen = 1'b1;
                end else if (w_f3_ok && f7_ok) begin
                    bus.alu_op  = f3_op(funct3, inst[30]);
                    bus.op1_sel = OP1_RS1;
                    bus.imm     = {59'b0, inst[24:20]};
                    bus.word_op = 1'b1;
                    bus.reg_wen = 1'b1;
                end
            end
            OPC_LUI: begin
                bus.imm     = imm_u;
                bus.reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                bus.op1_sel = OP1_PC;
                bus.imm     = imm_u;
                bus.reg_wen = 1'b1;
            end
            default: ;
        endcase
    end

    assign bus.valid   = in_valid;
    assign bus.pc      = pc;
    assign bus.rs1     = rs1_val;
    assign bus.rs2     = rs2_val;
    assign bus.rd_addr = bus.reg_wen ? inst[11:7] : 5'd0;   // Bubbles carry rd 0
    assign in_allowin  = bus.allowin;

    // Unknown instruction bits would decode silently as a bubble
    always_comb begin
        if (in_valid) begin
            assert (!$isunknown(inst)) else $error("inst unknown with valid high");
        end
    end

endmodule

`default_nettype wire

//--- src/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;

    // Major opcodes handled by the decoder
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

endpackage

`default_nettype wire

//--- src/stage_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stage_bus_if
    import rv_exec_pkg::*;
();

    logic      valid;
    logic      allowin;   // Receiver can take an item this cycle
    xlen_t     pc;
    xlen_t     rs1;
    xlen_t     rs2;
    xlen_t     imm;
    reg_addr_t rd_addr;
    logic      reg_wen;
    logic      word_op;   // 32-bit op, result sign-extended
    alu_op_e   alu_op;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;

    modport src (
        output valid, pc, rs1, rs2, imm, rd_addr, reg_wen, word_op,
        output alu_op, op1_sel, op2_sel,
        input  allowin
    );

    modport dst (
        input  valid, pc, rs1, rs2, imm, rd_addr, reg_wen, word_op,
        input  alu_op, op1_sel, op2_sel,
        output allowin
    );

endinterface

`default_nettype wire

//--- tests/tb_decode_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_exec
    import rv_exec_pkg::*;
();

    localparam int RESET_CYCLES    = 10;
    localparam int N_THRU          = 200;
    localparam int N_STALL         = 600;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * (N_THRU + N_STALL);

    typedef struct packed {
        xlen_t     result;
        reg_addr_t rd;
        logic      wen;
        xlen_t     pc;
        int        acc_cycle;
        logic      lat_chk;   // Latency is fixed only when nothing stalls
        int        id;
    } exp_rec_t;

    logic      I_sys_clk;
    logic      I_rst;
    logic      in_valid;
    logic      in_allowin;
    inst_t     inst;
    xlen_t     pc;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    logic      out_valid;
    logic      out_allowout;
    xlen_t     out_result;
    reg_addr_t out_rd_addr;
    logic      out_reg_wen;
    xlen_t     out_pc;

    logic [31:0] lfsr       = 32'h94da_07a7;
    int          cycle_cnt  = 0;
    int          item_id    = 0;
    string       phase_name = "reset";
    exp_rec_t    exp_q[$];
    logic        held       = 1'b0;
    exp_rec_t    held_rec;

    decode_exec_top u_dut (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .in_valid     (in_valid),
        .in_allowin   (in_allowin),
        .inst         (inst),
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .out_valid    (out_valid),
        .out_allowout (out_allowout),
        .out_result   (out_result),
        .out_rd_addr  (out_rd_addr),
        .out_reg_wen  (out_reg_wen),
        .out_pc       (out_pc)
    );

    always #5 I_sys_clk = ~I_sys_clk;

    always @(posedge I_sys_clk) cycle_cnt <= cycle_cnt + 1;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input string test, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s result: expected %h, actual %h", test, exp, act));
    endtask

    task automatic check_rd(input string test, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s rd: expected %0d, actual %0d", test, exp, act));
    endtask

    task automatic check_wen(input string test, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s reg_wen: expected %b, actual %b", test, exp, act));
    endtask

    task automatic check_pc(input string test, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s pc: expected %h, actual %h", test, exp, act));
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", test, exp, act));
    endtask

    task automatic check_latency(input string test, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("[ERROR] %s latency: expected %0d, actual %0d", test, exp, act));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        rand_bits = v;
    endfunction

    function automatic inst_t gen_inst();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [2:0]  f3w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        logic [6:0]  f7;
        kind = 4'(rand_bits(4));
        f3   = 3'(rand_bits(3));
        rd   = 5'(rand_bits(5));
        rs1  = 5'(rand_bits(5));
        rs2  = 5'(rand_bits(5));
        alt  = 1'(rand_bits(1));
        imm  = 12'(rand_bits(12));
        f3w  = (f3[1:0] == 2'd1) ? 3'd1 : (f3[1:0] == 2'd2) ? 3'd5 : 3'd0;
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd13: begin
                f7       = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                gen_inst = {f7, rs2, rs1, f3, rd, 7'h33};
            end
            4'd4, 4'd5, 4'd6, 4'd14: begin
                if (f3 == 3'd1) imm[11:6] = 6'h00;
                else if (f3 == 3'd5) imm[11:6] = alt ? 6'h10 : 6'h00;   // SRAI vs SRLI
                gen_inst = {imm, rs1, f3, rd, 7'h13};
            end
            4'd7, 4'd8: begin
                f7       = (alt && f3w != 3'd1) ? 7'h20 : 7'h00;
                gen_inst = {f7, rs2, rs1, f3w, rd, 7'h3b};
            end
            4'd9, 4'd10: begin
                if (f3w != 3'd0) imm[11:5] = (alt && f3w == 3'd5) ? 7'h20 : 7'h00;
                gen_inst = {imm, rs1, f3w, rd, 7'h1b};
            end
            4'd11:   gen_inst = {imm, rs1, f3, rd, 7'h37};
            4'd12:   gen_inst = {imm, rs1, f3, rd, 7'h17};
            default: begin
                case (f3[1:0])   // Load, store, branch, jal
                    2'd0:    f7 = 7'h03;
                    2'd1:    f7 = 7'h23;
                    2'd2:    f7 = 7'h63;
                    default: f7 = 7'h6f;
                endcase
                gen_inst = {imm, rs1, f3, rd, f7};
            end
        endcase
    endfunction

    function automatic xlen_t alu64(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    alu64 = alt ? a - b : a + b;
            3'd1:    alu64 = a << b[5:0];
            3'd2:    alu64 = {63'b0, $signed(a) < $signed(b)};
            3'd3:    alu64 = {63'b0, a < b};
            3'd4:    alu64 = a ^ b;
            3'd5: begin
                if (alt) alu64 = $signed(a) >>> b[5:0];
                else     alu64 = a >> b[5:0];
            end
            3'd6:    alu64 = a | b;
            default: alu64 = a & b;
        endcase
    endfunction

    function automatic logic [31:0] alu32(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    alu32 = alt ? a - b : a + b;
            3'd1:    alu32 = a << b[4:0];
            3'd5: begin
                if (alt) alu32 = $signed(a) >>> b[4:0];
                else     alu32 = a >> b[4:0];
            end
            default: alu32 = '0;
        endcase
    endfunction

    function automatic xlen_t ref_exec(input inst_t ins, input xlen_t pc_v, input xlen_t a,
                                       input xlen_t b, output logic wen, output reg_addr_t rd);
        logic [2:0]  f3;
        logic        alt;
        xlen_t       imm_i;
        xlen_t       imm_u;
        logic [31:0] w;
        xlen_t       res;
        f3    = ins[14:12];
        alt   = ins[30];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
        wen   = 1'b1;
        res   = '0;
        w     = '0;
        case (ins[6:0])
            7'h33:   res = alu64(f3, alt, a, b);
            7'h13:   res = alu64(f3, alt && f3 == 3'd5, a, imm_i);   // No SUBI
            7'h3b:   w   = alu32(f3, alt, a[31:0], b[31:0]);
            7'h1b:   w   = alu32(f3, alt && f3 == 3'd5, a[31:0], imm_i[31:0]);
            7'h37:   res = imm_u;
            7'h17:   res = pc_v + imm_u;
            default: wen = 1'b0;
        endcase
        if (ins[6:0] == 7'h3b || ins[6:0] == 7'h1b) res = {{32{w[31]}}, w};
        rd       = wen ? ins[11:7] : 5'd0;
        ref_exec = res;
    endfunction

    task automatic send_items(input int count, input logic stalls, input string name);
        int        sent;
        logic      pending;
        inst_t     ins;
        xlen_t     p;
        xlen_t     a;
        xlen_t     b;
        logic      wen;
        reg_addr_t rd;
        exp_rec_t  rec;
        sent       = 0;
        pending    = 1'b0;
        phase_name = name;
        while (sent < count) begin
            @(negedge I_sys_clk);
            out_allowout = stalls ? (rand_bits(2) != '0) : 1'b1;
            if (!pending && (!stalls || rand_bits(2) != '0)) begin
                ins     = gen_inst();
                p       = {62'(rand_bits(62)), 2'b00};
                a       = rand_bits(64);
                b       = rand_bits(64);
                inst    = ins;
                pc      = p;
                rs1_val = a;
                rs2_val = b;
                pending = 1'b1;
            end
            in_valid = pending;
            @(posedge I_sys_clk);
            if (!stalls && !in_allowin)
                abort_run("in_allowin went low while the output side was always ready");
            if (pending && in_allowin) begin
                rec.result    = ref_exec(ins, p, a, b, wen, rd);
                rec.rd        = rd;
                rec.wen       = wen;
                rec.pc        = p;
                rec.acc_cycle = cycle_cnt;
                rec.lat_chk   = !stalls;
                rec.id        = item_id;
                item_id++;
                exp_q.push_back(rec);
                pending = 1'b0;
                sent++;
            end
        end
        @(negedge I_sys_clk);
        in_valid     = 1'b0;
        out_allowout = 1'b1;
        while (exp_q.size() != 0) @(negedge I_sys_clk);
    endtask

    // Scoreboard on the output handshake
    always @(posedge I_sys_clk) begin : compare_outputs
        exp_rec_t rec;
        string    tag;
        if (!I_rst) begin
            if (held) begin
                check_flag("hold out_valid", 1'b1, out_valid);
                check_result("hold", held_rec.result, out_result);
                check_rd("hold", held_rec.rd, out_rd_addr);
                check_wen("hold", held_rec.wen, out_reg_wen);
                check_pc("hold", held_rec.pc, out_pc);
            end
            held            = out_valid && !out_allowout;
            held_rec.result = out_result;
            held_rec.rd     = out_rd_addr;
            held_rec.wen    = out_reg_wen;
            held_rec.pc     = out_pc;
            if (out_valid && out_allowout) begin
                if (exp_q.size() == 0) begin
                    abort_run("DUT delivered a result with no instruction outstanding");
                end else begin
                    rec = exp_q.pop_front();
                    tag = $sformatf("%s item %0d", phase_name, rec.id);
                    check_result(tag, rec.result, out_result);
                    check_rd(tag, rec.rd, out_rd_addr);
                    check_wen(tag, rec.wen, out_reg_wen);
                    check_pc(tag, rec.pc, out_pc);
                    if (rec.lat_chk) check_latency(tag, 2, cycle_cnt - rec.acc_cycle);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge I_sys_clk);
        abort_run("Timeout: the pipeline stopped delivering results");
    end

    initial begin
        I_sys_clk    = 1'b0;
        I_rst        = 1'b1;
        in_valid     = 1'b0;
        out_allowout = 1'b1;
        inst         = '0;
        pc           = '0;
        rs1_val      = '0;
        rs2_val      = '0;
        repeat (RESET_CYCLES) begin
            @(negedge I_sys_clk);
            check_flag("reset out_valid", 1'b0, out_valid);
            check_flag("reset in_allowin", 1'b1, in_allowin);
        end
        I_rst = 1'b0;
        @(negedge I_sys_clk);
        check_flag("after reset out_valid", 1'b0, out_valid);
        check_flag("after reset in_allowin", 1'b1, in_allowin);
        send_items(N_THRU, 1'b0, "throughput");
        send_items(N_STALL, 1'b1, "stall");
        repeat (3) @(negedge I_sys_clk);
        if (exp_q.size() == 0 && !out_valid) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run("DUT produced results after the last instruction");
        end
    end

endmodule

`default_nettype wire
